// File: tb.f
logic/uart_cfg_pkg.sv
logic/uart_reg_pkg.sv
logic/uart_des.sv
logic/uart_ser.sv
logic/uart_regs.sv
logic/uart_top.sv
test/uart_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       ?= uart_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Simulation passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: test/uart_tb.sv
module uart_tb import uart_cfg_pkg::*, uart_reg_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  // config rounds, bytes per round
  localparam int n_rnd  = 2;
  localparam int n_byte = 3;
  // slowest bit used, bdr 15
  localparam int max_bt = 16;
  // 40 frames at the slowest bit plus slack, in ns
  localparam longint wdg_ns = (40 * frm_bits * max_bt + 2000) * 100;
  // status polls before giving up on a flag
  localparam int poll_max = 2 * frm_bits * max_bt;

  logic             clk;
  logic             rst;
  logic             req;
  logic             wen;
  logic [adr_w-1:0] adr;
  logic [bus_w-1:0] wdt;
  logic [bus_w-1:0] rdt;
  logic             txd;
  logic             rxd;

  int seed = 48;

  // model state
  logic [bdr_w-1:0] m_bdr;
  logic [bdr_w-1:0] m_smp;
  logic [dat_w-1:0] m_buf;
  logic             m_full;
  logic             m_ovr;
  logic             m_frm;
  // bytes seen on txd by the monitor
  logic [dat_w-1:0] tx_seen[$];

  uart_top i_dut (
    .clk (clk),
    .rst (rst),
    .req (req),
    .wen (wen),
    .adr (adr),
    .wdt (wdt),
    .rdt (rdt),
    .txd (txd),
    .rxd (rxd)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  //////////////////////////////////////////////////
  // checks and bus access
  //////////////////////////////////////////////////

  task automatic check_val(input string name, input logic [15:0] got, input logic [15:0] exp);
    assert (got === exp) else begin
      $display("** Error: %s is %h, expected %h", name, got, exp);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task automatic bus_write(input logic [adr_w-1:0] a, input logic [bus_w-1:0] d);
    @(posedge clk);
    req <= 1'b1;
    wen <= 1'b1;
    adr <= a;
    wdt <= d;
    @(posedge clk);
    req <= 1'b0;
    wen <= 1'b0;
  endtask

  // rdt is stable by the falling edge after the req edge
  task automatic bus_read(input logic [adr_w-1:0] a, output logic [bus_w-1:0] d);
    @(posedge clk);
    req <= 1'b1;
    wen <= 1'b0;
    adr <= a;
    @(posedge clk);
    req <= 1'b0;
    @(negedge clk);
    d = rdt;
  endtask

  //////////////////////////////////////////////////
  // model
  //////////////////////////////////////////////////

  function automatic logic [15:0] exp_sts(input logic busy);
    logic [15:0] s;
    s              = '0;
    s[sts_tx_busy] = busy;
    s[sts_rx_full] = m_full;
    s[sts_rx_ovr]  = m_ovr;
    s[sts_rx_frm]  = m_frm;
    return s;
  endfunction

  // one frame on rxd as the receiver should see it
  task automatic model_rx(input logic [dat_w-1:0] b, input logic stop_low);
    if (stop_low) begin
      m_frm = 1'b1;
    end else begin
      if (m_full) m_ovr = 1'b1;
      m_full = 1'b1;
      m_buf  = b;
    end
  endtask

  // any sts read clears the sticky error flags
  task automatic sts_expect(input logic busy);
    logic [15:0] d;
    bus_read(adr_sts, d);
    check_val("sts", d, exp_sts(busy));
    m_ovr = 1'b0;
    m_frm = 1'b0;
  endtask

  task automatic rxd_expect();
    logic [15:0] d;
    bus_read(adr_rxd, d);
    check_val("rxd", d, {8'h00, m_buf});
    m_full = 1'b0;
  endtask

  // wait for a status bit, then compare the whole word
  task automatic poll_check(input int pos, input logic val);
    logic [15:0] s;
    int          n;
    n = 0;
    bus_read(adr_sts, s);
    while (s[pos] !== val) begin
      n++;
      if (n > poll_max) begin
        $display("status bit %0d never reached %0b", pos, val);
        $display("Simulation failed");
        $fatal(1);
      end
      bus_read(adr_sts, s);
    end
    check_val("sts", s, exp_sts(1'b0));
    m_ovr = 1'b0;
    m_frm = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // serial line
  //////////////////////////////////////////////////

  // lsb first, then one idle bit
  task automatic drive_frame(input logic [dat_w-1:0] b, input logic stop_low);
    logic [frm_bits-1:0] f;
    f = {~stop_low, b, 1'b0};
    for (int i = 0; i < frm_bits; i++) begin
      @(posedge clk);
      rxd <= f[i];
      repeat (int'(m_bdr)) @(posedge clk);
    end
    @(posedge clk);
    rxd <= 1'b1;
    repeat (int'(m_bdr)) @(posedge clk);
  endtask

  // txd sampled near the middle of each bit
  initial begin : line_monitor
    logic [dat_w-1:0] b;
    int               bt;
    forever begin
      @(negedge clk);
      if (!rst && txd === 1'b0) begin
        bt = int'(m_bdr) + 1;
        repeat (bt / 2) @(negedge clk);
        check_val("txd start bit", 16'(txd), 16'd0);
        for (int i = 0; i < dat_w; i++) begin
          repeat (bt) @(negedge clk);
          b[i] = txd;
        end
        repeat (bt) @(negedge clk);
        check_val("txd stop bit", 16'(txd), 16'd1);
        tx_seen.push_back(b);
      end
    end
  end

  initial begin : watchdog
    #(wdg_ns);
    $display("timeout, the run did not finish in time");
    $display("Simulation failed");
    $fatal(1);
  end

  //////////////////////////////////////////////////
  // test sequences
  //////////////////////////////////////////////////

  // second write lands while busy and must be dropped
  task automatic tx_byte_test();
    logic [31:0]      r;
    logic [dat_w-1:0] b;
    logic [dat_w-1:0] got;
    r = $random(seed);
    b = r[7:0];
    bus_write(adr_txd, r[15:0]);
    sts_expect(1'b1);
    r = $random(seed);
    bus_write(adr_txd, r[15:0]);
    poll_check(sts_tx_busy, 1'b0);
    check_val("tx frame count", 16'(tx_seen.size()), 16'd1);
    got = tx_seen.pop_front();
    check_val("txd byte", {8'h00, got}, {8'h00, b});
  endtask

  task automatic rx_byte_test();
    logic [31:0] r;
    r = $random(seed);
    drive_frame(r[7:0], 1'b0);
    model_rx(r[7:0], 1'b0);
    poll_check(sts_rx_full, 1'b1);
    rxd_expect();
    sts_expect(1'b0);
  endtask

  task automatic rx_err_test();
    logic [31:0] r;
    int          g;
    // two bytes, no read between
    r = $random(seed);
    drive_frame(r[7:0], 1'b0);
    model_rx(r[7:0], 1'b0);
    drive_frame(r[15:8], 1'b0);
    model_rx(r[15:8], 1'b0);
    poll_check(sts_rx_ovr, 1'b1);
    rxd_expect();
    sts_expect(1'b0);
    // good byte then a low stop bit, buffer stays full
    r = $random(seed);
    drive_frame(r[7:0], 1'b0);
    model_rx(r[7:0], 1'b0);
    drive_frame(r[15:8], 1'b1);
    model_rx(r[15:8], 1'b1);
    poll_check(sts_rx_frm, 1'b1);
    rxd_expect();
    sts_expect(1'b0);
    // glitch shorter than the sample point
    g = (m_smp > 1) ? 1 + int'(r[23:16]) % (int'(m_smp) - 1) : 1;
    @(posedge clk);
    rxd <= 1'b0;
    repeat (g) @(posedge clk);
    rxd <= 1'b1;
    repeat (frm_bits * (int'(m_bdr) + 1)) @(posedge clk);
    sts_expect(1'b0);
  endtask

  initial begin : stimulus
    logic [15:0] d;
    logic [31:0] r;
    rst    = 1'b1;
    req    = 1'b0;
    wen    = 1'b0;
    adr    = '0;
    wdt    = '0;
    rxd    = 1'b1;
    m_bdr  = 8'd15;
    m_smp  = 8'd7;
    m_buf  = '0;
    m_full = 1'b0;
    m_ovr  = 1'b0;
    m_frm  = 1'b0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;

    // state after reset
    sts_expect(1'b0);
    bus_read(adr_ctl, d);
    check_val("ctl", d, {m_smp, m_bdr});
    check_val("txd", 16'(txd), 16'd1);

    for (int rnd = 0; rnd < n_rnd; rnd++) begin
      r     = $random(seed);
      m_bdr = 8'd3 + (r[7:0] % 8'd13);
      m_smp = m_bdr / 8'd2;
      bus_write(adr_ctl, {m_smp, m_bdr});
      bus_read(adr_ctl, d);
      check_val("ctl", d, {m_smp, m_bdr});
      for (int i = 0; i < n_byte; i++) tx_byte_test();
      for (int i = 0; i < n_byte; i++) rx_byte_test();
      rx_err_test();
    end

    // nothing late on txd
    repeat (frm_bits * (int'(m_bdr) + 1)) @(posedge clk);
    check_val("tx frame count", 16'(tx_seen.size()), 16'd0);

    $display("Simulation passed");
    $finish;
  end

endmodule : uart_tb

// File: logic/uart_top.sv
module uart_top import uart_cfg_pkg::*, uart_reg_pkg::*; (
  input  logic             clk,
  input  logic             rst,
  // register bus
  input  logic             req,
  input  logic             wen,
  input  logic [adr_w-1:0] adr,
  input  logic [bus_w-1:0] wdt,
  output logic [bus_w-1:0] rdt,
  // serial lines
  output logic             txd,
  input  logic             rxd
);

  // config to both directions
  logic [bdr_w-1:0] cfg_bdr;
  logic [bdr_w-1:0] cfg_smp;

  // transmit path
  logic             tx_stb;
  logic [dat_w-1:0] tx_dat;
  logic             tx_busy;

  // receive path
  logic             rx_vld;
  logic [dat_w-1:0] rx_dat;
  logic             rx_frm;

  //////////////////////////////////////////////////
  // register bank
  //////////////////////////////////////////////////

  uart_regs i_regs (
    .clk     (clk),
    .rst     (rst),
    .req     (req),
    .wen     (wen),
    .adr     (adr),
    .wdt     (wdt),
    .rdt     (rdt),
    .cfg_bdr (cfg_bdr),
    .cfg_smp (cfg_smp),
    .tx_stb  (tx_stb),
    .tx_dat  (tx_dat),
    .tx_busy (tx_busy),
    .rx_vld  (rx_vld),
    .rx_dat  (rx_dat),
    .rx_frm  (rx_frm)
  );

  //////////////////////////////////////////////////
  // line side
  //////////////////////////////////////////////////

  uart_ser i_ser (
    .clk     (clk),
    .rst     (rst),
    .cfg_bdr (cfg_bdr),
    .tx_stb  (tx_stb),
    .tx_dat  (tx_dat),
    .tx_busy (tx_busy),
    .txd     (txd)
  );

  uart_des i_des (
    .clk     (clk),
    .rst     (rst),
    .cfg_bdr (cfg_bdr),
    .cfg_smp (cfg_smp),
    .rxd     (rxd),
    .rx_vld  (rx_vld),
    .rx_dat  (rx_dat),
    .rx_frm  (rx_frm)
  );

endmodule : uart_top

// File: logic/uart_regs.sv
module uart_regs import uart_cfg_pkg::*, uart_reg_pkg::*; (
  input  logic             clk,
  input  logic             rst,
  // register bus
  input  logic             req,
  input  logic             wen,
  input  logic [adr_w-1:0] adr,
  input  logic [bus_w-1:0] wdt,
  output logic [bus_w-1:0] rdt,
  // line config
  output logic [bdr_w-1:0] cfg_bdr,
  output logic [bdr_w-1:0] cfg_smp,
  // serializer side
  output logic             tx_stb,
  output logic [dat_w-1:0] tx_dat,
  input  logic             tx_busy,
  // deserializer side
  input  logic             rx_vld,
  input  logic [dat_w-1:0] rx_dat,
  input  logic             rx_frm
);

  // write word, two views
  bus_word_t        wrd;

  // decoded accesses
  logic             wr_ctl;
  logic             wr_txd;
  logic             rd_rxd;
  logic             rd_sts;
  logic             tx_go;

  // receive buffer and sticky flags
  logic [dat_w-1:0] rx_buf;
  logic             rx_full;
  logic             rx_ovr;
  logic             rx_frm_err;

  // status word
  logic [bus_w-1:0] sts;

  //////////////////////////////////////////////////
  // decode
  //////////////////////////////////////////////////

  assign wrd    = wdt;
  assign wr_ctl = req &  wen & (adr == adr_ctl);
  assign wr_txd = req &  wen & (adr == adr_txd);
  assign rd_rxd = req & ~wen & (adr == adr_rxd);
  assign rd_sts = req & ~wen & (adr == adr_sts);

  // also blocked on the strobe cycle, busy rises one edge later
  assign tx_go  = wr_txd & ~tx_busy & ~tx_stb;

  // config
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cfg_bdr <= bdr_w'(bdr_def);
      cfg_smp <= bdr_w'(smp_def);
    end else if (wr_ctl) begin
      cfg_bdr <= wrd.cfg.bdr;
      cfg_smp <= wrd.cfg.smp;
    end
  end

  //////////////////////////////////////////////////
  // transmit
  //////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      tx_stb <= 1'b0;
    end else begin
      tx_stb <= tx_go;
    end
  end

  always_ff @(posedge clk) begin
    if (tx_go) begin
      tx_dat <= wrd.dat.dat;
    end
  end

  //////////////////////////////////////////////////
  // receive
  //////////////////////////////////////////////////

  // newest byte always wins
  always_ff @(posedge clk) begin
    if (rx_vld) begin
      rx_buf <= rx_dat;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rx_full    <= 1'b0;
      rx_ovr     <= 1'b0;
      rx_frm_err <= 1'b0;
    end else begin
      // clears first, sets below take priority
      if (rd_rxd) begin
        rx_full <= 1'b0;
      end
      if (rd_sts) begin
        rx_ovr     <= 1'b0;
        rx_frm_err <= 1'b0;
      end
      if (rx_vld) begin
        rx_full <= 1'b1;
        if (rx_full) begin
          rx_ovr <= 1'b1;
        end
      end
      if (rx_frm) begin
        rx_frm_err <= 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // read back
  //////////////////////////////////////////////////

  // pending strobe already counts as busy
  always_comb begin
    sts              = '0;
    sts[sts_tx_busy] = tx_busy | tx_stb;
    sts[sts_rx_full] = rx_full;
    sts[sts_rx_ovr]  = rx_ovr;
    sts[sts_rx_frm]  = rx_frm_err;
  end

  // held until the next read
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rdt <= '0;
    end else if (req && !wen) begin
      case (adr)
        adr_ctl: rdt <= {cfg_smp, cfg_bdr};
        adr_txd: rdt <= bus_w'(tx_dat);
        adr_rxd: rdt <= bus_w'(rx_buf);
        adr_sts: rdt <= sts;
        default: rdt <= '0;
      endcase
    end
  end

endmodule : uart_regs

// File: logic/uart_ser.sv
module uart_ser import uart_cfg_pkg::*; (
  input  logic             clk,
  input  logic             rst,
  // bit period minus one
  input  logic [bdr_w-1:0] cfg_bdr,
  // start pulse with its byte
  input  logic             tx_stb,
  input  logic [dat_w-1:0] tx_dat,
  // high for the whole frame
  output logic             tx_busy,
  // serial line out
  output logic             txd
);

  // frame as it goes on the wire, lsb first
  logic [frm_bits-1:0] frm;
  logic [frm_bits-1:0] shf;

  // baud counter
  logic [bdr_w-1:0]    bdr_cnt;
  logic                bdr_end;

  // bit counter, 0 is the start bit
  logic [cnt_w-1:0]    bit_cnt;
  logic                bit_lst;

  // stop, data, start
  assign frm = {1'b1, tx_dat, 1'b0};

  assign bdr_end = (bdr_cnt == cfg_bdr);
  assign bit_lst = (bit_cnt == cnt_w'(frm_bits - 1));

  //////////////////////////////////////////////////
  // control and line register
  //////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      tx_busy <= 1'b0;
      bdr_cnt <= '0;
      bit_cnt <= '0;
      txd     <= 1'b1;
    end else if (tx_stb) begin
      // start bit goes out right away
      tx_busy <= 1'b1;
      bdr_cnt <= '0;
      bit_cnt <= '0;
      txd     <= frm[0];
    end else if (tx_busy) begin
      if (bdr_end) begin
        bdr_cnt <= '0;
        // next bit, idle high after the stop bit
        txd     <= shf[1];
        if (bit_lst) begin
          tx_busy <= 1'b0;
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end else begin
        bdr_cnt <= bdr_cnt + 1'b1;
      end
    end
  end

  // shift in ones so the line rests high
  always_ff @(posedge clk) begin
    if (tx_stb) begin
      shf <= frm;
    end else if (tx_busy && bdr_end) begin
      shf <= {1'b1, shf[frm_bits-1:1]};
    end
  end

endmodule : uart_ser

// File: logic/uart_des.sv
module uart_des import uart_cfg_pkg::*; (
  input  logic             clk,
  input  logic             rst,
  // bit period minus one, sample offset inside a bit
  input  logic [bdr_w-1:0] cfg_bdr,
  input  logic [bdr_w-1:0] cfg_smp,
  // serial line in
  input  logic             rxd,
  // byte strobe, no ready
  output logic             rx_vld,
  output logic [dat_w-1:0] rx_dat,
  // bad stop bit strobe
  output logic             rx_frm
);

  // line sync and edge detect
  logic             rxd_syn;
  logic             rxd_dly;
  logic             rxd_edg;

  // frame in progress
  logic             run;

  // baud counter
  logic [bdr_w-1:0] bdr_cnt;
  logic             bdr_end;
  logic             bdr_smp;

  // bit counter, 0 is the start bit
  logic [cnt_w-1:0] bit_cnt;
  logic             bit_fst;
  logic             bit_lst;

  // data shifter
  logic [dat_w-1:0] shf_dat;

  //////////////////////////////////////////////////
  // start edge
  //////////////////////////////////////////////////

  // idle line is high
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rxd_syn <= 1'b1;
      rxd_dly <= 1'b1;
    end else begin
      rxd_syn <= rxd;
      rxd_dly <= rxd_syn;
    end
  end

  assign rxd_edg = rxd_dly & ~rxd_syn;

  //////////////////////////////////////////////////
  // bit timing
  //////////////////////////////////////////////////

  assign bdr_end = (bdr_cnt == cfg_bdr);
  assign bdr_smp = (bdr_cnt == cfg_smp);
  assign bit_fst = (bit_cnt == '0);
  assign bit_lst = (bit_cnt == cnt_w'(frm_bits - 1));

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      run     <= 1'b0;
      bdr_cnt <= '0;
      bit_cnt <= '0;
    end else if (!run) begin
      // falling edge only counts while idle
      if (rxd_edg) begin
        run     <= 1'b1;
        bdr_cnt <= '0;
        bit_cnt <= '0;
      end
    end else begin
      // high start bit is a glitch
      // stop bit sample ends the frame early so the next edge is seen
      if (bdr_smp && ((bit_fst && rxd_syn) || bit_lst)) begin
        run <= 1'b0;
      end
      if (bdr_end) begin
        bdr_cnt <= '0;
        bit_cnt <= bit_cnt + 1'b1;
      end else begin
        bdr_cnt <= bdr_cnt + 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // data and strobes
  //////////////////////////////////////////////////

  // data bits only, lsb arrives first
  always_ff @(posedge clk) begin
    if (run && bdr_smp && !bit_fst && !bit_lst) begin
      shf_dat <= {rxd_syn, shf_dat[dat_w-1:1]};
    end
  end

  assign rx_dat = shf_dat;

  // stop bit sample cycle
  assign rx_vld = run & bdr_smp & bit_lst &  rxd_syn;
  assign rx_frm = run & bdr_smp & bit_lst & ~rxd_syn;

endmodule : uart_des

// File: logic/uart_reg_pkg.sv
package uart_reg_pkg;

  //////////////////////////////////////////////////
  // bus geometry
  //////////////////////////////////////////////////

  localparam int unsigned adr_w = 2;
  localparam int unsigned bus_w = 16;

  // register map
  localparam logic [adr_w-1:0] adr_ctl = 2'd0;
  localparam logic [adr_w-1:0] adr_txd = 2'd1;
  localparam logic [adr_w-1:0] adr_rxd = 2'd2;
  localparam logic [adr_w-1:0] adr_sts = 2'd3;

  // status word bit positions
  localparam int unsigned sts_tx_busy = 0;
  localparam int unsigned sts_rx_full = 1;
  localparam int unsigned sts_rx_ovr  = 2;
  localparam int unsigned sts_rx_frm  = 3;

  //////////////////////////////////////////////////
  // bus word views
  //////////////////////////////////////////////////

  // ctl view, sample point in the upper byte
  typedef struct packed {
    logic [uart_cfg_pkg::bdr_w-1:0] smp;
    logic [uart_cfg_pkg::bdr_w-1:0] bdr;
  } bus_cfg_t;

  // txd/rxd view, byte in the low bits
  typedef struct packed {
    logic [bus_w-uart_cfg_pkg::dat_w-1:0] rsv;
    logic [uart_cfg_pkg::dat_w-1:0]       dat;
  } bus_dat_t;

  typedef union packed {
    bus_cfg_t cfg;
    bus_dat_t dat;
  } bus_word_t;

endpackage : uart_reg_pkg

// File: logic/uart_cfg_pkg.sv
package uart_cfg_pkg;

  //////////////////////////////////////////////////
  // baud generator
  //////////////////////////////////////////////////

  // baud counter width, also width of each config field
  localparam int unsigned bdr_w = 8;

  // config values after reset
  // 16 clocks per bit, sample in the middle
  localparam int unsigned bdr_def = 15;
  localparam int unsigned smp_def = 7;

  //////////////////////////////////////////////////
  // frame format
  //////////////////////////////////////////////////

  // data bits per frame, sent lsb first
  localparam int unsigned dat_w = 8;

  // bit counter width
  // must hold frm_bits-1
  localparam int unsigned cnt_w = 4;

  // start + data + stop, no parity
  localparam int unsigned frm_bits = 1 + dat_w + 1;

endpackage : uart_cfg_pkg
